// ==== source/mat_pkg.sv ====
package mat_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 12;
    localparam int DIM_W = 6;

    // both memories span the full address range.
    localparam int MEM_WORDS = 1 << ADDR_W;

    // Q8.8 signed data word.
    typedef logic [DATA_W-1:0] word_t;

    // word address into operand or result memory.
    typedef logic [ADDR_W-1:0] addr_t;

    // matrix dimension (1 to 63) or index.
    typedef logic [DIM_W-1:0] dim_t;

    // dot lane states.
    typedef enum logic [1:0] {
        LANE_IDLE,     // waiting for a job.
        LANE_CALC,     // one term per cycle.
        LANE_HANDOFF,  // waiting for a collector credit.
        LANE_RELEASE   // hands the credit back to the dispatcher.
    } lane_state_t;

endpackage

// ==== source/operand_ram.sv ====
module operand_ram import mat_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic  clk,
    input  logic  we,
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  addr_t rd_addr_a [NUM_LANES],
    output word_t rd_data_a [NUM_LANES],
    input  addr_t rd_addr_b [NUM_LANES],
    output word_t rd_data_b [NUM_LANES]
);

    word_t mem [MEM_WORDS];

    // single load port used only between runs.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // every lane fetches its A and B operands in the same cycle
    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_read
            assign rd_data_a[i] = mem[rd_addr_a[i]];  // row operand.
            assign rd_data_b[i] = mem[rd_addr_b[i]];  // column operand.
        end
    endgenerate

endmodule

// ==== source/row_dispatcher.sv ====
module row_dispatcher import mat_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  dim_t                 a_rows,
    input  dim_t                 b_cols,
    output logic [NUM_LANES-1:0] job_valid,
    output dim_t                 job_row,
    output dim_t                 job_col,
    input  logic [NUM_LANES-1:0] job_done,
    output logic                 dispatch_idle
);

    logic                 running;
    dim_t                 rows_q;
    dim_t                 cols_q;
    dim_t                 row;
    dim_t                 col;
    logic [NUM_LANES-1:0] credit;
    logic [NUM_LANES-1:0] grant;
    logic                 last_col;
    logic                 last_row;

    // lowest set credit bit wins.
    assign grant = running ? (credit & (~credit + 1'b1)) : '0;

    assign last_col = (col == cols_q - 6'd1);
    assign last_row = (row == rows_q - 6'd1);
    assign dispatch_idle = ~running;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            row <= '0;
            col <= '0;
            credit <= '1;       // one credit per lane.
            job_valid <= '0;
        end else begin
            job_valid <= grant;
            credit <= (credit & ~grant) | job_done;
            if (start && !running) begin
                running <= 1'b1;
                row <= '0;
                col <= '0;
            end else if (|grant) begin
                if (last_col) begin
                    col <= '0;
                    if (last_row) begin
                        running <= 1'b0;  // last element issued.
                    end else begin
                        row <= row + 6'd1;
                    end
                end else begin
                    col <= col + 6'd1;
                end
            end
        end
    end

    // dimensions and the job payload
    always_ff @(posedge clk) begin
        if (start && !running) begin
            rows_q <= a_rows;
            cols_q <= b_cols;
        end
        if (|grant) begin
            job_row <= row;
            job_col <= col;
        end
    end

endmodule

// ==== source/dot_lane.sv ====
module dot_lane import mat_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  job_valid,
    input  dim_t  job_row,
    input  dim_t  job_col,
    input  addr_t a_base,
    input  addr_t b_base,
    input  addr_t c_base,
    input  dim_t  a_cols,
    input  dim_t  b_cols,
    output addr_t rd_addr_a,
    output addr_t rd_addr_b,
    input  word_t rd_data_a,
    input  word_t rd_data_b,
    output logic  res_valid,
    output addr_t res_addr,
    output word_t res_data,
    input  logic  res_credit,
    output logic  job_done
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    lane_state_t       state;
    dim_t              term_idx;
    word_t             sum;
    logic [CW-1:0]     credits;
    logic signed [31:0] product_full;
    logic signed [31:0] product_shifted;
    word_t             term;
    logic              send;

    // Q8.8 product shifted back by 8 and cut to the low 16 bits.
    assign product_full = $signed(rd_data_a) * $signed(rd_data_b);
    assign product_shifted = product_full >>> 8;
    assign term = product_shifted[15:0];

    assign send = (state == LANE_HANDOFF) && (credits != '0);
    assign res_valid = send;
    assign res_data = sum;
    assign job_done = (state == LANE_RELEASE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= LANE_IDLE;
            term_idx <= '0;
            credits <= CW'(FIFO_DEPTH);
        end else begin
            credits <= credits + CW'(res_credit) - CW'(send);
            case (state)
                LANE_IDLE: begin
                    if (job_valid) begin
                        state <= LANE_CALC;
                        term_idx <= '0;
                    end
                end
                LANE_CALC: begin
                    term_idx <= term_idx + 6'd1;
                    if (term_idx == a_cols - 6'd1) begin
                        state <= LANE_HANDOFF;
                    end
                end
                LANE_HANDOFF: begin
                    if (send) begin
                        state <= LANE_RELEASE;
                    end
                end
                LANE_RELEASE: begin
                    state <= LANE_IDLE;
                end
                default: begin
                    state <= LANE_IDLE;
                end
            endcase
        end
    end

    // address walk and accumulate
    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && job_valid) begin
            rd_addr_a <= a_base + addr_t'(job_row) * addr_t'(a_cols);  // start of row.
            rd_addr_b <= b_base + addr_t'(job_col);                     // top of column.
            res_addr <= c_base + addr_t'(job_row) * addr_t'(b_cols) + addr_t'(job_col);
            sum <= '0;
        end else if (state == LANE_CALC) begin
            rd_addr_a <= rd_addr_a + 12'd1;
            rd_addr_b <= rd_addr_b + addr_t'(b_cols);  // next row of B.
            sum <= sum + term;                          // wraps mod 2^16.
        end
    end

endmodule

// ==== source/result_collector.sv ====
module result_collector import mat_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int FIFO_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic [NUM_LANES-1:0] res_valid,
    input  addr_t                res_addr [NUM_LANES],
    input  word_t                res_data [NUM_LANES],
    output logic [NUM_LANES-1:0] res_credit,
    input  dim_t                 a_rows,
    input  dim_t                 b_cols,
    input  logic                 dispatch_idle,
    input  addr_t                rd_addr,
    output word_t                rd_data,
    output logic                 done
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    addr_t                fifo_addr [NUM_LANES][FIFO_DEPTH];
    word_t                fifo_data [NUM_LANES][FIFO_DEPTH];
    logic [PW-1:0]        wr_ptr [NUM_LANES];
    logic [PW-1:0]        rd_ptr [NUM_LANES];
    logic [CW-1:0]        fill [NUM_LANES];
    logic [NUM_LANES-1:0] not_empty;
    logic [NUM_LANES-1:0] pop;
    logic [LW-1:0]        rr_last;
    logic [LW-1:0]        sel;
    logic                 sel_valid;
    logic [11:0]          expected;
    logic [11:0]          written;
    logic                 active;
    word_t                res_mem [MEM_WORDS];

    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_fifo
            assign not_empty[i] = (fill[i] != '0);

            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    wr_ptr[i] <= '0;
                    rd_ptr[i] <= '0;
                    fill[i] <= '0;
                end else begin
                    if (res_valid[i]) begin
                        wr_ptr[i] <= (wr_ptr[i] == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr[i] + 1'b1;
                    end
                    if (pop[i]) begin
                        rd_ptr[i] <= (rd_ptr[i] == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr[i] + 1'b1;
                    end
                    fill[i] <= fill[i] + CW'(res_valid[i]) - CW'(pop[i]);
                end
            end

            always_ff @(posedge clk) begin
                if (res_valid[i]) begin
                    fifo_addr[i][wr_ptr[i]] <= res_addr[i];
                    fifo_data[i][wr_ptr[i]] <= res_data[i];
                end
            end
        end
    endgenerate

    // round-robin pick that starts after the last lane served
    always_comb begin
        int idx;
        sel = rr_last;
        sel_valid = 1'b0;
        pop = '0;
        for (int off = NUM_LANES; off >= 1; off--) begin
            idx = (int'(rr_last) + off) % NUM_LANES;
            if (not_empty[idx]) begin
                sel = LW'(idx);
                sel_valid = 1'b1;
            end
        end
        if (sel_valid) begin
            pop[sel] = 1'b1;
        end
    end

    assign res_credit = pop;  // credit goes back with every pop.

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            res_mem[fifo_addr[sel][rd_ptr[sel]]] <= fifo_data[sel][rd_ptr[sel]];
        end
    end

    assign rd_data = res_mem[rd_addr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rr_last <= '0;
            active <= 1'b0;
            done <= 1'b0;
            written <= '0;
            expected <= '0;
        end else begin
            if (sel_valid) begin
                rr_last <= sel;
            end
            if (start) begin
                active <= 1'b1;
                done <= 1'b0;
                written <= '0;
                expected <= 12'(a_rows) * 12'(b_cols);
            end else begin
                if (sel_valid) begin
                    written <= written + 12'd1;
                end
                if (active && written == expected && dispatch_idle && !(|not_empty)) begin
                    done <= 1'b1;   // every element is in memory.
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/matmul_top.sv ====
module matmul_top import mat_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int FIFO_DEPTH = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_en,
    input  addr_t load_addr,
    input  word_t load_data,
    input  logic  start,
    input  addr_t a_base,
    input  addr_t b_base,
    input  addr_t c_base,
    input  dim_t  a_rows,
    input  dim_t  a_cols,
    input  dim_t  b_cols,
    input  addr_t rd_addr,
    output word_t rd_data,
    output logic  done
);

    logic [NUM_LANES-1:0] job_valid;
    logic [NUM_LANES-1:0] job_done;
    dim_t                 job_row;
    dim_t                 job_col;
    logic                 dispatch_idle;
    addr_t                lane_addr_a [NUM_LANES];
    addr_t                lane_addr_b [NUM_LANES];
    word_t                lane_data_a [NUM_LANES];
    word_t                lane_data_b [NUM_LANES];
    logic [NUM_LANES-1:0] res_valid;
    addr_t                res_addr [NUM_LANES];
    word_t                res_data [NUM_LANES];
    logic [NUM_LANES-1:0] res_credit;
    logic                 run_busy;
    logic                 run_start;

    // start only counts while no run is in progress.
    assign run_start = start & ~run_busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_busy <= 1'b0;
        end else if (run_start) begin
            run_busy <= 1'b1;
        end else if (done) begin
            run_busy <= 1'b0;
        end
    end

    operand_ram #(.NUM_LANES(NUM_LANES)) u_operand_ram (
        .clk(clk), .we(load_en), .wr_addr(load_addr), .wr_data(load_data),
        .rd_addr_a(lane_addr_a), .rd_data_a(lane_data_a),
        .rd_addr_b(lane_addr_b), .rd_data_b(lane_data_b)
    );

    row_dispatcher #(.NUM_LANES(NUM_LANES)) u_dispatcher (
        .clk(clk), .reset(reset), .start(run_start), .a_rows(a_rows), .b_cols(b_cols),
        .job_valid(job_valid), .job_row(job_row), .job_col(job_col),
        .job_done(job_done), .dispatch_idle(dispatch_idle)
    );

    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_lane
            dot_lane #(.FIFO_DEPTH(FIFO_DEPTH)) u_lane (
                .clk(clk), .reset(reset), .job_valid(job_valid[i]),
                .job_row(job_row), .job_col(job_col),
                .a_base(a_base), .b_base(b_base), .c_base(c_base),
                .a_cols(a_cols), .b_cols(b_cols),
                .rd_addr_a(lane_addr_a[i]), .rd_addr_b(lane_addr_b[i]),
                .rd_data_a(lane_data_a[i]), .rd_data_b(lane_data_b[i]),
                .res_valid(res_valid[i]), .res_addr(res_addr[i]), .res_data(res_data[i]),
                .res_credit(res_credit[i]), .job_done(job_done[i])
            );
        end
    endgenerate

    result_collector #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_collector (
        .clk(clk), .reset(reset), .start(run_start),
        .res_valid(res_valid), .res_addr(res_addr), .res_data(res_data),
        .res_credit(res_credit), .a_rows(a_rows), .b_cols(b_cols),
        .dispatch_idle(dispatch_idle), .rd_addr(rd_addr), .rd_data(rd_data), .done(done)
    );

endmodule

// ==== sim/matmul_props.sv ====
module collector_props #(
    parameter int NUM_LANES = 4,
    parameter int FIFO_DEPTH = 2,
    parameter int CW = $clog2(FIFO_DEPTH + 1)
) (
    input logic                 clk,
    input logic                 reset,
    input logic [NUM_LANES-1:0] res_valid,
    input logic [NUM_LANES-1:0] res_credit,
    input logic [CW-1:0]        fill [NUM_LANES],
    input logic                 done
);

    logic [NUM_LANES-1:0] full_lane;
    logic [NUM_LANES-1:0] empty_lane;
    int                   violations = 0;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            full_lane[k] = (fill[k] == CW'(FIFO_DEPTH));
            empty_lane[k] = (fill[k] == '0);
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        (res_valid & full_lane) == '0)
        else begin
            $error("result pushed into a full lane FIFO");
            violations++;
        end

    no_credit_when_empty: assert property (@(posedge clk) disable iff (reset)
        (res_credit & empty_lane) == '0)
        else begin
            $error("credit returned for an empty lane FIFO");
            violations++;
        end

    // done only once every FIFO has drained.
    no_done_with_data: assert property (@(posedge clk) disable iff (reset)
        !(done && !(&empty_lane)))
        else begin
            $error("done high while a lane FIFO still holds data");
            violations++;
        end

endmodule

bind result_collector collector_props #(
    .NUM_LANES(NUM_LANES),
    .FIFO_DEPTH(FIFO_DEPTH)
) u_props (
    .clk(clk),
    .reset(reset),
    .res_valid(res_valid),
    .res_credit(res_credit),
    .fill(fill),
    .done(done)
);

// ==== sim/matmul_tb.sv ====
module matmul_tb import mat_pkg::*; ();

    localparam int NUM_CASES = 8;
    localparam int DONE_TIMEOUT = 20000;
    localparam logic [1:0] MODE_IDENT = 2'd0;
    localparam logic [1:0] MODE_RAND = 2'd1;
    localparam logic [1:0] MODE_NEG = 2'd2;

    typedef struct packed {
        dim_t       rows;
        dim_t       inner;
        dim_t       cols;
        addr_t      a_at;
        addr_t      b_at;
        addr_t      c_at;
        logic [1:0] mode;
        logic       interrupt;  // second start while running.
    } case_t;

    localparam case_t CASES [NUM_CASES] = '{
        '{6'd3, 6'd3, 6'd3, 12'd0,   12'd64,  12'd0,    MODE_IDENT, 1'b0},
        '{6'd1, 6'd1, 6'd1, 12'd128, 12'd136, 12'd16,   MODE_RAND,  1'b0},
        '{6'd5, 6'd7, 6'd3, 12'd160, 12'd224, 12'd32,   MODE_RAND,  1'b0},
        '{6'd8, 6'd6, 6'd8, 12'd256, 12'd320, 12'd64,   MODE_RAND,  1'b0},
        '{6'd8, 6'd1, 6'd8, 12'd384, 12'd400, 12'd128,  MODE_RAND,  1'b0},
        '{6'd4, 6'd5, 6'd6, 12'd448, 12'd480, 12'd192,  MODE_NEG,   1'b0},
        '{6'd6, 6'd4, 6'd5, 12'd512, 12'd544, 12'd256,  MODE_RAND,  1'b1},
        '{6'd2, 6'd9, 6'd2, 12'd576, 12'd600, 12'd4090, MODE_NEG,   1'b1}
    };

    logic  clk = 1'b0;
    logic  reset;
    logic  load_en;
    addr_t load_addr;
    word_t load_data;
    logic  start;
    addr_t a_base;
    addr_t b_base;
    addr_t c_base;
    dim_t  a_rows;
    dim_t  a_cols;
    dim_t  b_cols;
    addr_t rd_addr;
    word_t rd_data;
    logic  done;

    word_t  a_m [MEM_WORDS];
    word_t  b_m [MEM_WORDS];
    word_t  c_m [MEM_WORDS];
    integer seed;
    int     mismatch_count;
    int     failure_count;
    logic   done_q = 1'b0;
    int     done_rise_total = 0;

    matmul_top #(.NUM_LANES(4), .FIFO_DEPTH(2)) UUT (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .start(start), .a_base(a_base), .b_base(b_base),
        .c_base(c_base), .a_rows(a_rows), .a_cols(a_cols), .b_cols(b_cols),
        .rd_addr(rd_addr), .rd_data(rd_data), .done(done)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        done_q <= done;
        if (done === 1'b1 && done_q !== 1'b1) begin
            done_rise_total <= done_rise_total + 1;
        end
    end

    // Q8.8 product shifted right by 8 and cut to 16 bits.
    function automatic word_t fx_mul(word_t x, word_t y);
        int prod;
        prod = int'($signed(x)) * int'($signed(y));
        return word_t'(prod >>> 8);
    endfunction

    function automatic word_t extreme_value(int pick);
        case (pick)
            0: return 16'h8000;
            1: return 16'h8001;
            2: return 16'h7fff;
            3: return 16'hff00;  // -1.0.
            4: return 16'hffff;
            default: return 16'h7f00;
        endcase
    endfunction

    function automatic word_t gen_value(logic [1:0] mode);
        int pick;
        if (mode == MODE_NEG) begin
            pick = int'($unsigned($random(seed)) % 32'd6);
            return extreme_value(pick);
        end
        return word_t'($random(seed));
    endfunction

    task automatic load_word(addr_t addr, word_t data);
        @(posedge clk);
        #1;
        load_en = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    task automatic load_case(case_t tc);
        int inner;
        int cols;
        inner = int'(tc.inner);
        cols = int'(tc.cols);
        for (int r = 0; r < int'(tc.rows); r++) begin
            for (int k = 0; k < inner; k++) begin
                a_m[r * inner + k] = gen_value(tc.mode);
                load_word(tc.a_at + addr_t'(r * inner + k), a_m[r * inner + k]);
            end
        end
        for (int k = 0; k < inner; k++) begin
            for (int c = 0; c < cols; c++) begin
                if (tc.mode == MODE_IDENT) begin
                    b_m[k * cols + c] = (k == c) ? 16'h0100 : 16'h0000;
                end else begin
                    b_m[k * cols + c] = gen_value(tc.mode);
                end
                load_word(tc.b_at + addr_t'(k * cols + c), b_m[k * cols + c]);
            end
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic compute_model(case_t tc);
        word_t sum;
        int    inner;
        int    cols;
        inner = int'(tc.inner);
        cols = int'(tc.cols);
        for (int r = 0; r < int'(tc.rows); r++) begin
            for (int c = 0; c < cols; c++) begin
                sum = '0;
                for (int k = 0; k < inner; k++) begin
                    sum = sum + fx_mul(a_m[r * inner + k], b_m[k * cols + c]);  // wraps.
                end
                c_m[r * cols + c] = sum;
            end
        end
    endtask

    task automatic check_results(case_t tc, int idx);
        int pos;
        for (int r = 0; r < int'(tc.rows); r++) begin
            for (int c = 0; c < int'(tc.cols); c++) begin
                pos = r * int'(tc.cols) + c;
                @(posedge clk);
                #1;
                rd_addr = tc.c_at + addr_t'(pos);
                @(negedge clk);
                assert (rd_data === c_m[pos]) else begin
                    mismatch_count++;
                    $display("MISMATCH at %0t: case %0d C[%0d][%0d] got %h expected %h",
                             $time, idx, r, c, rd_data, c_m[pos]);
                end
            end
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic run_case(int idx);
        case_t tc;
        int    rise_before;
        int    cycles;
        tc = CASES[idx];
        @(posedge clk);
        #1;
        a_base = tc.a_at;
        b_base = tc.b_at;
        c_base = tc.c_at;
        a_rows = tc.rows;
        a_cols = tc.inner;
        b_cols = tc.cols;
        load_case(tc);
        compute_model(tc);
        rise_before = done_rise_total;
        pulse_start();
        @(negedge clk);
        assert (done === 1'b0) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: case %0d done still high after start", $time, idx);
        end
        if (tc.interrupt) begin
            pulse_start();  // must be ignored mid-run.
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            failure_count++;
            $display("case %0d: done did not rise within %0d cycles", idx, DONE_TIMEOUT);
        end else begin
            repeat (10) @(negedge clk);
            assert (done === 1'b1 && done_rise_total - rise_before == 1) else begin
                mismatch_count++;
                $display("MISMATCH at %0t: case %0d done rose %0d times, now %b",
                         $time, idx, done_rise_total - rise_before, done);
            end
            check_results(tc, idx);
        end
    endtask

    initial begin
        seed = 32'h5701;
        mismatch_count = 0;
        failure_count = 0;
        reset = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        start = 1'b0;
        a_base = '0;
        b_base = '0;
        c_base = '0;
        a_rows = 6'd1;
        a_cols = 6'd1;
        b_cols = 6'd1;
        rd_addr = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        if (UUT.u_collector.u_props.violations != 0) begin
            failure_count = failure_count + UUT.u_collector.u_props.violations;
            $display("collector assertions failed %0d times",
                     UUT.u_collector.u_props.violations);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/mat_pkg.sv
source/operand_ram.sv
source/row_dispatcher.sv
source/dot_lane.sv
source/result_collector.sv
source/matmul_top.sv
sim/matmul_props.sv
sim/matmul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module matmul_tb -f sources.f

./obj_dir/Vmatmul_tb +verilator+error+limit+1000 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
